/* design/lau_pkg.sv */
// shared definitions for the add/subtract unit
// prefix-network structure selection and default word width
`default_nettype none

package lau_pkg;

	// structure of the carry prefix network
	// SLOW builds a serial ripple chain
	// MEDIUM builds a Brent-Kung tree
	// FAST builds a Sklansky tree
	typedef enum logic [1:0] {
		SLOW,
		MEDIUM,
		FAST
	} speed_e;

	// word width used when the top level is not overridden
	localparam int default_width = 16;

endpackage

`default_nettype wire

/* design/prefix_and_or.sv */
// parallel-prefix generate/propagate network
// serial, Brent-Kung and Sklansky structures chosen by the speed parameter
`default_nettype none

module prefix_and_or #(
	parameter int width = lau_pkg::default_width,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] gi,
	input  logic [width-1:0] pi,
	output logic [width-1:0] go,
	output logic [width-1:0] po
);
	import lau_pkg::*;

	// number of tree levels, one at least even for width 2
	localparam int levels = (width > 1) ? $clog2(width) : 1;

	// and-or prefix operator, returns {g, p}
	// hi is the upper (more significant) group, lo the lower one
	function automatic logic [1:0] pfx_op(input logic g_hi, input logic p_hi,
		input logic g_lo, input logic p_lo);
		logic g_out;
		logic p_out;
		g_out = g_hi | (p_hi & g_lo);
		p_out = p_hi & p_lo;
		return {g_out, p_out};
	endfunction

	case (speed)
		SLOW: begin : gen_serial
			// ripple chain, each bit waits for its neighbour
			logic [width-1:0] g_c;
			logic [width-1:0] p_c;

			assign g_c[0] = gi[0];
			assign p_c[0] = pi[0];
			for (genvar i = 1; i < width; i++) begin : gen_bit
				assign {g_c[i], p_c[i]} = pfx_op(gi[i], pi[i], g_c[i-1], p_c[i-1]);
			end

			assign go = g_c;
			assign po = p_c;
		end

		MEDIUM: begin : gen_brent_kung
			// stage 0 is the input, stages 1..levels the up sweep
			// stages levels+1..2*levels the down sweep
			logic [width-1:0] g_s [0:2*levels];
			logic [width-1:0] p_s [0:2*levels];

			assign g_s[0] = gi;
			assign p_s[0] = pi;

			// up sweep, combine pairs at distance 2^l on the odd ends of each block
			for (genvar l = 0; l < levels; l++) begin : gen_up
				for (genvar i = 0; i < width; i++) begin : gen_bit
					if (((i + 1) % (2 ** (l + 1))) == 0) begin : gen_op
						assign {g_s[l+1][i], p_s[l+1][i]} = pfx_op(g_s[l][i], p_s[l][i],
							g_s[l][i-2**l], p_s[l][i-2**l]);
					end else begin : gen_pass
						assign g_s[l+1][i] = g_s[l][i];
						assign p_s[l+1][i] = p_s[l][i];
					end
				end
			end

			// down sweep, fill in the middle positions from the widest span downwards
			for (genvar d = 0; d < levels; d++) begin : gen_down
				localparam int l = levels - 1 - d;
				for (genvar i = 0; i < width; i++) begin : gen_bit
					if ((((i + 1) % (2 ** (l + 1))) == 2 ** l) && (i >= 2 ** (l + 1)))
					begin : gen_op
						assign {g_s[levels+d+1][i], p_s[levels+d+1][i]} = pfx_op(
							g_s[levels+d][i], p_s[levels+d][i],
							g_s[levels+d][i-2**l], p_s[levels+d][i-2**l]);
					end else begin : gen_pass
						assign g_s[levels+d+1][i] = g_s[levels+d][i];
						assign p_s[levels+d+1][i] = p_s[levels+d][i];
					end
				end
			end

			assign go = g_s[2*levels];
			assign po = p_s[2*levels];
		end

		default: begin : gen_sklansky
			// divide and conquer, upper half of each block takes the
			// last bit of the lower half at every level
			logic [width-1:0] g_s [0:levels];
			logic [width-1:0] p_s [0:levels];

			assign g_s[0] = gi;
			assign p_s[0] = pi;

			for (genvar l = 0; l < levels; l++) begin : gen_lvl
				for (genvar i = 0; i < width; i++) begin : gen_bit
					if (((i >> l) & 1) == 1) begin : gen_op
						// last bit of the lower half of this block
						localparam int j = ((i >> l) << l) - 1;
						assign {g_s[l+1][i], p_s[l+1][i]} = pfx_op(g_s[l][i], p_s[l][i],
							g_s[l][j], p_s[l][j]);
					end else begin : gen_pass
						assign g_s[l+1][i] = g_s[l][i];
						assign p_s[l+1][i] = p_s[l][i];
					end
				end
			end

			assign go = g_s[levels];
			assign po = p_s[levels];
		end
	endcase

endmodule

`default_nettype wire

/* design/add_v.sv */
// prefix carry-lookahead adder with carry-in
// produces the sum and the two's complement overflow flag
`default_nettype none

module add_v #(
	parameter int width = lau_pkg::default_width,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             ci,
	output logic [width-1:0] s,
	output logic             v
);

	// prefix inputs and carries out
	logic [width-1:0] gi;
	logic [width-1:0] pi;
	logic [width-1:0] go;
	// half-sum per bit
	logic [width-1:0] pt;

	// bit 0 absorbs the carry-in as a full-adder majority
	// its propagate is zero so nothing passes through it
	assign gi[0] = (a[0] & b[0]) | (a[0] & ci) | (b[0] & ci);
	assign pi[0] = 1'b0;
	assign pt[0] = a[0] ^ b[0];

	for (genvar i = 1; i < width; i++) begin : gen_pre
		assign gi[i] = a[i] & b[i];
		assign pi[i] = a[i] | b[i];
		// xor from the and/or terms already at hand
		assign pt[i] = ~gi[i] & pi[i];
	end

	// group propagate stays open
	// the sum needs the carries alone
	prefix_and_or #(
		.width(width),
		.speed(speed)
	) i_prefix (
		.gi(gi),
		.pi(pi),
		.go(go),
		.po()
	);

	// go[i] is the carry out of bit i
	assign s = pt ^ {go[width-2:0], ci};
	// carry into the sign bit against carry out of it
	assign v = go[width-1] ^ go[width-2];

endmodule

`default_nettype wire

/* design/op_config.sv */
// operating mode register
// subtract select and saturation enable, written by a one-cycle strobe
`default_nettype none

module op_config (
	input  logic clk,
	input  logic rst,
	input  logic cfg_we,
	input  logic cfg_sub,
	input  logic cfg_sat,
	output logic mode_sub,
	output logic sat_en
);

	// mode holds across any number of operations until the next write
	// reset gives plain add without clamping
	always_ff @(posedge clk) begin
		if (rst) begin
			mode_sub <= 1'b0;
			sat_en   <= 1'b0;
		end else if (cfg_we) begin
			mode_sub <= cfg_sub;
			sat_en   <= cfg_sat;
		end
	end

endmodule

`default_nettype wire

/* design/sat_addsub.sv */
// registered signed add/subtract datapath
// operand conditioning for subtract, prefix adder, saturation and output stage
`default_nettype none

module sat_addsub #(
	parameter int width = lau_pkg::default_width,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             cin,
	input  logic             mode_sub,
	input  logic             sat_en,
	output logic [width-1:0] res,
	output logic             ovf,
	output logic             res_valid
);

	// most positive and most negative two's complement values
	localparam logic [width-1:0] max_val = {1'b0, {(width-1){1'b1}}};
	localparam logic [width-1:0] min_val = {1'b1, {(width-1){1'b0}}};

	// conditioned adder operands
	logic [width-1:0] b_op;
	logic             c_op;
	// raw adder outputs
	logic [width-1:0] sum;
	logic             v;
	// result after clamping
	logic [width-1:0] sat_sum;

	// a - b - cin = a + ~b + 1 - cin = a + ~b + ~cin
	// so cin turns into a borrow-in just by inverting it
	assign b_op = mode_sub ? ~b : b;
	assign c_op = mode_sub ? ~cin : cin;

	add_v #(
		.width(width),
		.speed(speed)
	) i_add (
		.a (a),
		.b (b_op),
		.ci(c_op),
		.s (sum),
		.v (v)
	);

	// overflow can only push away from the sign of a in both modes,
	// so the sign of a picks the clamp value
	always_comb begin
		sat_sum = sum;
		if (sat_en && v) begin
			sat_sum = a[width-1] ? min_val : max_val;
		end
	end

	// output stage, one cycle after the strobe
	// result and flag hold while no operation is strobed
	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			res       <= '0;
			ovf       <= 1'b0;
		end else begin
			res_valid <= in_valid;
			if (in_valid) begin
				res <= sat_sum;
				// raw flag, reported even when clamped
				ovf <= v;
			end
		end
	end

endmodule

`default_nettype wire

/* design/lau_addsub_top.sv */
// top level of the add/subtract unit
// mode register beside the registered datapath
`default_nettype none

module lau_addsub_top #(
	parameter int width = lau_pkg::default_width,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             cfg_we,
	input  logic             cfg_sub,
	input  logic             cfg_sat,
	input  logic             in_valid,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             cin,
	output logic [width-1:0] res,
	output logic             ovf,
	output logic             res_valid
);

	// configuration levels into the datapath
	logic mode_sub;
	logic sat_en;

	op_config i_cfg (
		.clk     (clk),
		.rst     (rst),
		.cfg_we  (cfg_we),
		.cfg_sub (cfg_sub),
		.cfg_sat (cfg_sat),
		.mode_sub(mode_sub),
		.sat_en  (sat_en)
	);

	sat_addsub #(
		.width(width),
		.speed(speed)
	) i_dp (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.cin      (cin),
		.mode_sub (mode_sub),
		.sat_en   (sat_en),
		.res      (res),
		.ovf      (ovf),
		.res_valid(res_valid)
	);

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// testbench clock and reset source
// 8 ns clock, reset held high for a number of rising edges
`default_nettype none

module tb_clock #(
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// free running clock, 4 ns per phase
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// release on a falling edge like every other DUT input
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
// result monitor for the add/subtract unit
// reference model, configuration tracking and per-cycle output comparison
`default_nettype none

module tb_checker #(
	parameter int width = lau_pkg::default_width
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             cfg_we,
	input  logic             cfg_sub,
	input  logic             cfg_sat,
	input  logic             in_valid,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             cin,
	input  logic [width-1:0] res,
	input  logic             ovf,
	input  logic             res_valid,
	output int               err_count,
	output int               check_count,
	output int               result_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// model of the mode register
	logic             sub_m = 1'b0;
	logic             sat_m = 1'b0;
	// expected outputs after the last rising edge
	logic             exp_valid = 1'b0;
	logic [width-1:0] exp_res = '0;
	logic             exp_ovf = 1'b0;
	// operation behind the expectation, for error lines
	logic [width-1:0] op_a = '0;
	logic [width-1:0] op_b = '0;
	logic             op_sub = 1'b0;
	logic             seen_reset = 1'b0;
	int               errors = 0;
	int               checks = 0;
	int               results = 0;

	assign err_count    = errors;
	assign check_count  = checks;
	assign result_count = results;

	// exact signed result two bits wider than the word, then range check
	// returns {overflow, result}
	function automatic logic [width:0] ref_calc(input logic [width-1:0] x,
		input logic [width-1:0] y, input logic c, input logic sub, input logic sat);
		logic signed [width+1:0] ex;
		logic signed [width+1:0] hi;
		logic signed [width+1:0] lo;
		logic signed [width+1:0] cx;
		logic                    o;
		logic [width-1:0]        r;
		cx = {{(width+1){1'b0}}, c};
		hi = {3'b000, {(width-1){1'b1}}};
		lo = {3'b111, {(width-1){1'b0}}};
		if (sub) begin
			ex = $signed({{2{x[width-1]}}, x}) - $signed({{2{y[width-1]}}, y}) - cx;
		end else begin
			ex = $signed({{2{x[width-1]}}, x}) + $signed({{2{y[width-1]}}, y}) + cx;
		end
		o = (ex > hi) || (ex < lo);
		r = ex[width-1:0];
		// clamp to the side the exact value ran off to
		if (sat && o) begin
			r = (ex > hi) ? hi[width-1:0] : lo[width-1:0];
		end
		return {o, r};
	endfunction

	task automatic report_mismatch(input string what, input logic [width-1:0] got,
		input logic [width-1:0] want);
		errors++;
		$display("Fail at %0t ns: %s is %h, expected %h (a %h, b %h, sub %0b)",
			$time, what, got, want, op_a, op_b, op_sub);
	endtask

	// predict on the rising edge, inputs were set on the falling edge before
	always @(posedge clk) begin
		logic [width:0] pred;
		if (rst) begin
			seen_reset = 1'b1;
			sub_m      = 1'b0;
			sat_m      = 1'b0;
			exp_valid  = 1'b0;
			exp_res    = '0;
			exp_ovf    = 1'b0;
		end else begin
			exp_valid = in_valid;
			if (in_valid) begin
				// mode from before this edge, a write here counts from next cycle
				pred    = ref_calc(a, b, cin, sub_m, sat_m);
				exp_res = pred[width-1:0];
				exp_ovf = pred[width];
				op_a    = a;
				op_b    = b;
				op_sub  = sub_m;
			end
			if (cfg_we) begin
				sub_m = cfg_sub;
				sat_m = cfg_sat;
			end
		end
	end

	// compare mid cycle where registered outputs are settled
	// res and ovf must hold through idle cycles too
	always @(negedge clk) begin
		if (seen_reset) begin
			checks++;
			if (res_valid === 1'b1) begin
				results++;
			end
			if (res_valid !== exp_valid) begin
				report_mismatch("res_valid", width'(res_valid), width'(exp_valid));
			end
			if (res !== exp_res) begin
				report_mismatch("res", res, exp_res);
			end
			if (ovf !== exp_ovf) begin
				report_mismatch("ovf", width'(ovf), width'(exp_ovf));
			end
		end
	end

endmodule

`default_nettype wire

/* bench/tb_top.sv */
// testbench top for the add/subtract unit
// DUT, clock, checker, falling-edge stimulus, xorshift operands and timeout
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;
	import lau_pkg::*;

	localparam int width = default_width;
	localparam logic [width-1:0] max_val = {1'b0, {(width-1){1'b1}}};
	localparam logic [width-1:0] min_val = {1'b1, {(width-1){1'b0}}};

	// test lengths
	localparam int reset_cycles = 5;
	localparam int n_rand = 200;
	localparam int gap_every = 20;
	localparam int n_dir = 8;
	localparam int n_sat_rand = 50;
	localparam int n_mix = 24;
	localparam int n_writes = 3;
	localparam int drain = 4;
	// every strobe, write and idle cycle plus margin
	localparam int timeout_limit = reset_cycles + 1
		+ 2 * (n_rand + n_rand / gap_every)
		+ 2 * (n_dir + n_sat_rand + n_sat_rand / gap_every)
		+ n_mix + n_writes + drain + 50;

	logic             clk;
	logic             rst;
	logic             cfg_we;
	logic             cfg_sub;
	logic             cfg_sat;
	logic             in_valid;
	logic [width-1:0] a;
	logic [width-1:0] b;
	logic             cin;
	logic [width-1:0] res;
	logic             ovf;
	logic             res_valid;
	int               err_count;
	int               check_count;
	int               result_count;
	int               n_issued = 0;
	int               cycle_count = 0;
	logic [31:0]      rng_state = 32'd77;

	tb_clock #(.reset_cycles(reset_cycles)) i_clk (.clk(clk), .rst(rst));

	lau_addsub_top #(
		.width(width),
		.speed(FAST)
	) i_dut (
		.clk(clk), .rst(rst),
		.cfg_we(cfg_we), .cfg_sub(cfg_sub), .cfg_sat(cfg_sat),
		.in_valid(in_valid), .a(a), .b(b), .cin(cin),
		.res(res), .ovf(ovf), .res_valid(res_valid)
	);

	tb_checker #(.width(width)) i_chk (
		.clk(clk), .rst(rst),
		.cfg_we(cfg_we), .cfg_sub(cfg_sub), .cfg_sat(cfg_sat),
		.in_valid(in_valid), .a(a), .b(b), .cin(cin),
		.res(res), .ovf(ovf), .res_valid(res_valid),
		.err_count(err_count), .check_count(check_count), .result_count(result_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] t;
		t = s ^ (s << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	// two draws cover words up to 64 bits
	task automatic rand_word(output logic [width-1:0] w);
		logic [63:0] wide;
		rng_state = xorshift32(rng_state);
		wide[63:32] = rng_state;
		rng_state = xorshift32(rng_state);
		wide[31:0] = rng_state;
		w = wide[width-1:0];
	endtask

	task automatic drive_op(input logic [width-1:0] x, input logic [width-1:0] y,
		input logic c);
		@(negedge clk);
		cfg_we   = 1'b0;
		in_valid = 1'b1;
		a        = x;
		b        = y;
		cin      = c;
		n_issued++;
	endtask

	// operands keep changing so a held res is really held
	task automatic drive_idle(input int n);
		repeat (n) begin
			@(negedge clk);
			cfg_we   = 1'b0;
			in_valid = 1'b0;
			rand_word(a);
			rand_word(b);
		end
	endtask

	task automatic write_cfg(input logic sub, input logic sat);
		@(negedge clk);
		in_valid = 1'b0;
		cfg_we   = 1'b1;
		cfg_sub  = sub;
		cfg_sat  = sat;
	endtask

	// back to back strobes with an idle slot every gap operations
	task automatic random_ops(input int n, input int gap);
		logic [width-1:0] x;
		logic [width-1:0] y;
		for (int i = 0; i < n; i++) begin
			rand_word(x);
			rand_word(y);
			rng_state = xorshift32(rng_state);
			drive_op(x, y, rng_state[7]);
			if ((i + 1) % gap == 0) begin
				drive_idle(1);
			end
		end
	endtask

	// edge operands, several overflow in one mode or the other
	task automatic directed_ops();
		drive_op(max_val, 1, 1'b0);
		drive_op(min_val, 1, 1'b0);
		drive_op(max_val, max_val, 1'b1);
		drive_op(min_val, min_val, 1'b0);
		drive_op(min_val, max_val, 1'b1);
		drive_op(max_val, min_val, 1'b0);
		drive_op('0, '0, 1'b1);
		drive_op('1, min_val, 1'b0);
	endtask

	// strobe every cycle while the mode is rewritten in some of them
	task automatic mixed_ops(input int n);
		logic [width-1:0] x;
		logic [width-1:0] y;
		for (int i = 0; i < n; i++) begin
			rand_word(x);
			rand_word(y);
			rng_state = xorshift32(rng_state);
			drive_op(x, y, rng_state[3]);
			cfg_we  = rng_state[9];
			cfg_sub = rng_state[12];
			cfg_sat = rng_state[20];
		end
	endtask

	// guard against a stuck run
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		cfg_we   = 1'b0;
		cfg_sub  = 1'b0;
		cfg_sat  = 1'b0;
		in_valid = 1'b0;
		a        = '0;
		b        = '0;
		cin      = 1'b0;
		@(negedge rst);
		drive_idle(1);
		// reset mode, plain add
		random_ops(n_rand, gap_every);
		// subtract with borrow
		write_cfg(1'b1, 1'b0);
		random_ops(n_rand, gap_every);
		// clamping in both modes
		write_cfg(1'b0, 1'b1);
		directed_ops();
		random_ops(n_sat_rand, gap_every);
		write_cfg(1'b1, 1'b1);
		directed_ops();
		random_ops(n_sat_rand, gap_every);
		mixed_ops(n_mix);
		drive_idle(drain);
		@(posedge clk);
		$display("checks: %0d, errors: %0d, results: %0d of %0d strobes",
			check_count, err_count, result_count, n_issued);
		if (err_count == 0 && result_count == n_issued && check_count > 0) begin
			$display("TESTS PASSED");
		end else begin
			if (result_count != n_issued) begin
				$display("number of results does not match the number of strobes");
			end
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
design/lau_pkg.sv
design/prefix_and_or.sv
design/add_v.sv
design/op_config.sv
design/sat_addsub.sv
design/lau_addsub_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* Bender.yml */
package:
  name: lau_addsub

sources:
  - design/lau_pkg.sv
  - design/prefix_and_or.sv
  - design/add_v.sv
  - design/op_config.sv
  - design/sat_addsub.sv
  - design/lau_addsub_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_checker.sv
      - bench/tb_top.sv
